// ==== src/lbuf_cfg_pkg.sv ====
/* Buffer configuration constants shared by every block.
   The packed structs are sized by LBW_DEFAULT, so no instance may use a wider LBW. */
`default_nettype none

package lbuf_cfg_pkg;

	//==========================================================================
	// Configuration ids
	//==========================================================================
	// Number of block size entries in the table
	localparam int N_ICFG = 4;
	// Width of one id
	localparam int ICFG_BW = (N_ICFG > 1) ? $clog2(N_ICFG) : 1;

	//==========================================================================
	// Buffer geometry
	//==========================================================================
	// Words carried by one SRAM write beat
	localparam int VSIZE = 4;
	// Default local address width, 64 words
	localparam int LBW_DEFAULT = 6;

endpackage

`default_nettype wire

// ==== src/lbuf_types_pkg.sv ====
/* Packed structs exchanged between decode, allocator and fill tracker.
   Addresses and sizes use the LBW_DEFAULT width whatever LBW an instance selects. */
`default_nettype none

package lbuf_types_pkg;

	import lbuf_cfg_pkg::*;

	//==========================================================================
	// Decoded request
	//==========================================================================
	// Id of the request and the block size looked up for it
	typedef struct packed {
		logic [ICFG_BW-1:0]   id;
		logic [LBW_DEFAULT:0] size;
	} alloc_req_t;

	//==========================================================================
	// Pending linear output
	//==========================================================================
	// Ring address of a granted block and the words it needs
	typedef struct packed {
		logic [LBW_DEFAULT-1:0] addr;
		logic [LBW_DEFAULT:0]   size;
	} lbuf_entry_t;

	//==========================================================================
	// DMA command
	//==========================================================================
	// Where the DMA engine writes, how much and for which id
	typedef struct packed {
		logic [LBW_DEFAULT-1:0] addr;
		logic [LBW_DEFAULT:0]   size;
		logic [ICFG_BW-1:0]     id;
	} dma_cmd_t;

endpackage

`default_nettype wire

// ==== src/size_table_decode.sv ====
/* Size table of N_ICFG entries, all zero after reset.
   A table write is seen by decode on the following cycle; lookups are combinational. */
`timescale 1ns/1ps
`default_nettype none

module size_table_decode
	import lbuf_cfg_pkg::*;
	import lbuf_types_pkg::*;
#(
	parameter int LBW = LBW_DEFAULT
) (
	input  logic               i_clk,
	input  logic               i_rst,
	// Table write port
	input  logic               i_cfg_we,
	input  logic [ICFG_BW-1:0] i_cfg_id,
	input  logic [LBW:0]       i_cfg_size,
	// Ids to decode
	input  logic [ICFG_BW-1:0] i_alloc_id,
	input  logic [ICFG_BW-1:0] i_free_id,
	// Decoded sizes
	output alloc_req_t         o_alloc_req,
	output logic [LBW:0]       o_free_size
);

	// One size per id, LBW+1 bits so a block may span the whole ring
	logic [LBW:0] size_r [N_ICFG];

	//==========================================================================
	// Table storage
	//==========================================================================
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < N_ICFG; i++) begin
				size_r[i] <= '0;
			end
		end else if (i_cfg_we) begin
			size_r[i_cfg_id] <= i_cfg_size;
		end
	end

	//==========================================================================
	// Id decode
	//==========================================================================
	// Allocation side carries the id along for the DMA command
	always_comb begin
		o_alloc_req.id   = i_alloc_id;
		o_alloc_req.size = (LBW_DEFAULT + 1)'(size_r[i_alloc_id]);
	end

	// Free side only needs the size to return
	assign o_free_size = size_r[i_free_id];

endmodule

`default_nettype wire

// ==== src/lbuf_fifo.sv ====
/* Register FIFO of DEPTH entries, head visible on o_data while o_rdy is high.
   A push while full is ignored, so the writer must check o_full first. */
`timescale 1ns/1ps
`default_nettype none

module lbuf_fifo #(
	parameter int  DEPTH     = 5,
	parameter type payload_t = logic [7:0]
) (
	input  logic     i_clk,
	input  logic     i_rst,
	// Write side
	input  logic     i_push,
	input  payload_t i_data,
	// Read side, ready/acknowledge
	input  logic     i_ack,
	output logic     o_rdy,
	output payload_t o_data,
	output logic     o_full
);

	localparam int PTR_BW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BW = $clog2(DEPTH + 1);

	payload_t          mem [DEPTH];
	logic [PTR_BW-1:0] wr_ptr_r;
	logic [PTR_BW-1:0] rd_ptr_r;
	logic [CNT_BW-1:0] count_r;
	logic              do_push;
	logic              do_pop;

	//==========================================================================
	// Status
	//==========================================================================
	assign o_rdy   = count_r != '0;
	assign o_full  = count_r == CNT_BW'(DEPTH);
	assign do_push = i_push && !o_full;
	// Pop only on an acknowledged transfer
	assign do_pop  = i_ack && o_rdy;
	assign o_data  = mem[rd_ptr_r];

	//==========================================================================
	// Payload storage
	//==========================================================================
	always_ff @(posedge i_clk) begin
		if (do_push) begin
			mem[wr_ptr_r] <= i_data;
		end
	end

	//==========================================================================
	// Pointers and occupancy
	//==========================================================================
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
			count_r  <= '0;
		end else begin
			// Pointers wrap at DEPTH, which need not be a power of two
			if (do_push) begin
				wr_ptr_r <= (wr_ptr_r == PTR_BW'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_r <= (rd_ptr_r == PTR_BW'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
			end
			// Simultaneous push and pop leaves the count alone
			if (do_push && !do_pop) begin
				count_r <= count_r + 1'b1;
			end else if (do_pop && !do_push) begin
				count_r <= count_r - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/space_allocator.sv ====
/* Grants ring space in request order; the ack is combinational on i_alloc_rdy.
   A block-done pulse wins over a grant in the same cycle and leaves the cursor at 0. */
`timescale 1ns/1ps
`default_nettype none

module space_allocator
	import lbuf_cfg_pkg::*;
	import lbuf_types_pkg::*;
#(
	parameter int LBW   = LBW_DEFAULT,
	parameter int DEPTH = 5
) (
	input  logic         i_clk,
	input  logic         i_rst,
	// Allocation request, ready/acknowledge
	input  logic         i_alloc_rdy,
	input  alloc_req_t   i_alloc_req,
	output logic         o_alloc_ack,
	// Space returned by a free
	input  logic         i_free_dval,
	input  logic [LBW:0] i_free_size,
	// End of block, ring restarts at address 0
	input  logic         i_blkdone_dval,
	// Pending queue level from the fill tracker
	input  logic         i_fill_full,
	// DMA command, ready/acknowledge
	input  logic         i_cmd_ack,
	output logic         o_cmd_rdy,
	output dma_cmd_t     o_cmd,
	// Pending entry toward the fill tracker
	output logic         o_entry_push,
	output lbuf_entry_t  o_entry
);

	// Whole ring is free after reset
	localparam logic [LBW:0] CAPACITY = 1 << LBW;

	logic [LBW:0]   capacity_r;
	logic [LBW:0]   capacity_w;
	logic [LBW-1:0] cur_r;
	logic [LBW-1:0] cur_w;
	logic [LBW:0]   alloc_size;
	logic           has_space;
	logic           cmd_full;
	dma_cmd_t       cmd_in;

	//==========================================================================
	// Grant decision
	//==========================================================================
	// Granted sizes never exceed the capacity, so LBW+1 bits hold them
	assign alloc_size = i_alloc_req.size[LBW:0];
	assign has_space  = capacity_r >= i_alloc_req.size;
	// Both queues need room, every grant lands in each of them
	assign o_alloc_ack = i_alloc_rdy && has_space && !cmd_full && !i_fill_full;

	//==========================================================================
	// Capacity and cursor
	//==========================================================================
	always_comb begin
		capacity_w = capacity_r;
		if (o_alloc_ack) begin
			capacity_w = capacity_w - alloc_size;
		end
		// Free in the same edge as a grant adds on top
		if (i_free_dval) begin
			capacity_w = capacity_w + i_free_size;
		end
	end

	always_comb begin
		cur_w = cur_r;
		// Advance modulo 2^LBW by dropping the carry
		if (o_alloc_ack) begin
			cur_w = cur_r + alloc_size[LBW-1:0];
		end
		if (i_blkdone_dval) begin
			cur_w = '0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			capacity_r <= CAPACITY;
			cur_r      <= '0;
		end else begin
			capacity_r <= capacity_w;
			cur_r      <= cur_w;
		end
	end

	//==========================================================================
	// Outgoing payloads
	//==========================================================================
	// Block address is the cursor before the advance
	always_comb begin
		cmd_in.addr = LBW_DEFAULT'(cur_r);
		cmd_in.size = i_alloc_req.size;
		cmd_in.id   = i_alloc_req.id;
	end

	always_comb begin
		o_entry.addr = LBW_DEFAULT'(cur_r);
		o_entry.size = i_alloc_req.size;
	end

	assign o_entry_push = o_alloc_ack;

	// DMA queue, o_cmd_rdy rises the cycle after the grant
	lbuf_fifo #(
		.DEPTH     (DEPTH),
		.payload_t (dma_cmd_t)
	) u_cmd_fifo (
		.i_clk  (i_clk),
		.i_rst  (i_rst),
		.i_push (o_alloc_ack),
		.i_data (cmd_in),
		.i_ack  (i_cmd_ack),
		.o_rdy  (o_cmd_rdy),
		.o_data (o_cmd),
		.o_full (cmd_full)
	);

endmodule

`default_nettype wire

// ==== src/fill_tracker.sv ====
/* Releases pending addresses in grant order once enough words are written.
   Write beats are counted for the whole ring, not per block; a beat may fill the next block. */
`timescale 1ns/1ps
`default_nettype none

module fill_tracker
	import lbuf_cfg_pkg::*;
	import lbuf_types_pkg::*;
#(
	parameter int LBW   = LBW_DEFAULT,
	parameter int DEPTH = 5
) (
	input  logic        i_clk,
	input  logic        i_rst,
	// Pending entry from the allocator
	input  logic        i_entry_push,
	input  lbuf_entry_t i_entry,
	// One SRAM write beat of VSIZE words
	input  logic        i_re_dval,
	// Linear output, ready/acknowledge
	input  logic        i_linear_ack,
	output logic        o_fill_full,
	output logic        o_linear_rdy,
	output lbuf_entry_t o_linear
);

	// One spare bit over the ring size covers a beat past the last block
	localparam int WC_BW = LBW + 2;

	lbuf_entry_t      head;
	logic             head_vld;
	logic             filled;
	logic             release_ack;
	logic [WC_BW-1:0] wcount_r;
	logic [WC_BW-1:0] wcount_w;

	//==========================================================================
	// Pending queue
	//==========================================================================
	// Pops only on a released transfer, never on a raw ack
	lbuf_fifo #(
		.DEPTH     (DEPTH),
		.payload_t (lbuf_entry_t)
	) u_entry_fifo (
		.i_clk  (i_clk),
		.i_rst  (i_rst),
		.i_push (i_entry_push),
		.i_data (i_entry),
		.i_ack  (release_ack),
		.o_rdy  (head_vld),
		.o_data (head),
		.o_full (o_fill_full)
	);

	//==========================================================================
	// Release
	//==========================================================================
	assign filled       = wcount_r >= head.size;
	assign o_linear_rdy = head_vld && filled;
	assign release_ack  = i_linear_ack && o_linear_rdy;
	assign o_linear     = head;

	//==========================================================================
	// Written word count
	//==========================================================================
	always_comb begin
		wcount_w = wcount_r;
		if (i_re_dval) begin
			wcount_w = wcount_w + WC_BW'(VSIZE);
		end
		// Consumed block gives its words back
		if (release_ack) begin
			wcount_w = wcount_w - WC_BW'(head.size);
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wcount_r <= '0;
		end else begin
			wcount_r <= wcount_w;
		end
	end

endmodule

`default_nettype wire

// ==== src/lbuf_manager_top.sv ====
/* Local buffer space manager for a ring of 2^LBW words.
   LBW must not exceed LBW_DEFAULT; at most DEPTH grants wait in each queue. */
`timescale 1ns/1ps
`default_nettype none

module lbuf_manager_top
	import lbuf_cfg_pkg::*;
	import lbuf_types_pkg::*;
#(
	parameter int LBW   = LBW_DEFAULT,
	parameter int DEPTH = 5
) (
	input  logic               i_clk,
	input  logic               i_rst,
	// Size table write
	input  logic               i_cfg_we,
	input  logic [ICFG_BW-1:0] i_cfg_id,
	input  logic [LBW:0]       i_cfg_size,
	// Allocation request
	input  logic               i_alloc_rdy,
	input  logic [ICFG_BW-1:0] i_alloc_id,
	output logic               o_alloc_ack,
	// Free, write beat and block end pulses
	input  logic               i_free_dval,
	input  logic [ICFG_BW-1:0] i_free_id,
	input  logic               i_re_dval,
	input  logic               i_blkdone_dval,
	// Linear output
	output logic               o_linear_rdy,
	input  logic               i_linear_ack,
	output lbuf_entry_t        o_linear,
	// DMA command
	output logic               o_cmd_rdy,
	input  logic               i_cmd_ack,
	output dma_cmd_t           o_cmd
);

	alloc_req_t   alloc_req;
	logic [LBW:0] free_size;
	logic         entry_push;
	lbuf_entry_t  entry;
	logic         fill_full;

	//==========================================================================
	// Decode
	//==========================================================================
	size_table_decode #(
		.LBW (LBW)
	) u_decode (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_cfg_we    (i_cfg_we),
		.i_cfg_id    (i_cfg_id),
		.i_cfg_size  (i_cfg_size),
		.i_alloc_id  (i_alloc_id),
		.i_free_id   (i_free_id),
		.o_alloc_req (alloc_req),
		.o_free_size (free_size)
	);

	//==========================================================================
	// Execute
	//==========================================================================
	space_allocator #(
		.LBW   (LBW),
		.DEPTH (DEPTH)
	) u_alloc (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_alloc_rdy    (i_alloc_rdy),
		.i_alloc_req    (alloc_req),
		.o_alloc_ack    (o_alloc_ack),
		.i_free_dval    (i_free_dval),
		.i_free_size    (free_size),
		.i_blkdone_dval (i_blkdone_dval),
		.i_fill_full    (fill_full),
		.i_cmd_ack      (i_cmd_ack),
		.o_cmd_rdy      (o_cmd_rdy),
		.o_cmd          (o_cmd),
		.o_entry_push   (entry_push),
		.o_entry        (entry)
	);

	//==========================================================================
	// Result
	//==========================================================================
	fill_tracker #(
		.LBW   (LBW),
		.DEPTH (DEPTH)
	) u_fill (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_entry_push (entry_push),
		.i_entry      (entry),
		.i_re_dval    (i_re_dval),
		.i_linear_ack (i_linear_ack),
		.o_fill_full  (fill_full),
		.o_linear_rdy (o_linear_rdy),
		.o_linear     (o_linear)
	);

endmodule

`default_nettype wire

// ==== verification/lbuf_tb_model.svh ====
/* Reference model of the buffer manager, included inside the testbench module.
   Needs LBW, DEPTH and the DUT input signals of the enclosing module in scope. */
`ifndef LBUF_TB_MODEL_SVH
`define LBUF_TB_MODEL_SVH

//==========================================================================
// Model state
//==========================================================================
// Size table copy, remaining capacity and ring cursor
int unsigned tbl_size [N_ICFG];
int unsigned cap;
int unsigned cursor;
// Words written and not yet consumed
int unsigned wcount;
dma_cmd_t    cmd_q [$];
lbuf_entry_t fill_q [$];
int unsigned grant_count;

// Expected outputs for the cycle being checked
logic        exp_ack;
logic        exp_cmd_rdy;
logic        exp_lin_rdy;
dma_cmd_t    exp_cmd;
lbuf_entry_t exp_lin;

function automatic void reset_model();
	for (int i = 0; i < N_ICFG; i++) begin
		tbl_size[i] = 0;
	end
	cap         = 1 << LBW;
	cursor      = 0;
	wcount      = 0;
	grant_count = 0;
	cmd_q.delete();
	fill_q.delete();
endfunction

// Words still owed to the blocks waiting for release
function automatic int unsigned queued_words();
	int unsigned sum;
	sum = 0;
	foreach (fill_q[i]) begin
		sum += fill_q[i].size;
	end
	return sum;
endfunction

//==========================================================================
// Prediction
//==========================================================================
function automatic void predict_outputs(input logic alloc_rdy,
	input logic [ICFG_BW-1:0] alloc_id);
	exp_cmd_rdy = cmd_q.size() != 0;
	exp_cmd     = exp_cmd_rdy ? cmd_q[0] : '0;
	// Head is held back until its whole block is written
	exp_lin_rdy = fill_q.size() != 0 && wcount >= fill_q[0].size;
	exp_lin     = fill_q.size() != 0 ? fill_q[0] : '0;
	// Grant needs space and room in both queues
	exp_ack     = alloc_rdy && cap >= tbl_size[alloc_id] &&
		cmd_q.size() < DEPTH && fill_q.size() < DEPTH;
endfunction

//==========================================================================
// Clock edge
//==========================================================================
function automatic void advance_model();
	dma_cmd_t    cmd;
	lbuf_entry_t ent;
	int unsigned size;
	size = tbl_size[i_alloc_id];
	if (i_cmd_ack && exp_cmd_rdy) begin
		void'(cmd_q.pop_front());
	end
	// Consumed block takes its words out of the count
	if (i_linear_ack && exp_lin_rdy) begin
		wcount -= fill_q[0].size;
		void'(fill_q.pop_front());
	end
	if (i_re_dval) begin
		wcount += VSIZE;
	end
	if (exp_ack) begin
		cmd.addr = LBW_DEFAULT'(cursor);
		cmd.size = (LBW_DEFAULT + 1)'(size);
		cmd.id   = i_alloc_id;
		ent.addr = LBW_DEFAULT'(cursor);
		ent.size = (LBW_DEFAULT + 1)'(size);
		cmd_q.push_back(cmd);
		fill_q.push_back(ent);
		cap    -= size;
		cursor  = (cursor + size) % (1 << LBW);
		grant_count++;
	end
	if (i_free_dval) begin
		cap += tbl_size[i_free_id];
	end
	// Block end overrides any advance in the same edge
	if (i_blkdone_dval) begin
		cursor = 0;
	end
	// Table write is seen from the next cycle on
	if (i_cfg_we) begin
		tbl_size[i_cfg_id] = i_cfg_size;
	end
endfunction

`endif

// ==== verification/lbuf_manager_tb.sv ====
/* Random testbench for the buffer manager, checked against lbuf_tb_model.svh.
   Inputs change on the falling edge, outputs are compared 1 ns later. */
`timescale 1ns/1ps
`default_nettype none

module lbuf_manager_tb
	import lbuf_cfg_pkg::*;
	import lbuf_types_pkg::*;
();

	localparam int LBW            = LBW_DEFAULT;
	localparam int DEPTH          = 5;
	localparam int CLK_PERIOD     = 40;
	localparam int N_OPS          = 400;
	localparam int TIMEOUT_CYCLES = N_OPS * 40;
	// Largest block size written into the table
	localparam int MAX_SIZE       = 24;

	logic               i_clk;
	logic               i_rst;
	logic               i_cfg_we;
	logic [ICFG_BW-1:0] i_cfg_id;
	logic [LBW:0]       i_cfg_size;
	logic               i_alloc_rdy;
	logic [ICFG_BW-1:0] i_alloc_id;
	logic               o_alloc_ack;
	logic               i_free_dval;
	logic [ICFG_BW-1:0] i_free_id;
	logic               i_re_dval;
	logic               i_blkdone_dval;
	logic               o_linear_rdy;
	logic               i_linear_ack;
	lbuf_entry_t        o_linear;
	logic               o_cmd_rdy;
	logic               i_cmd_ack;
	dma_cmd_t           o_cmd;

	integer             seed;
	int                 cycle_count;
	int                 mismatch_count;
	int                 other_count;
	// Stimulus phase controls
	logic               alloc_en;
	logic               cfg_en;
	logic               free_en;
	logic               cmd_ack_en;
	logic               lin_ack_en;
	int unsigned        free_odds;
	logic               granted;
	int                 bp_grants;
	// Transfers the DUT actually completed on each output
	int                 cmd_taken;
	int                 lin_taken;
	// Ids granted and not yet freed
	logic [ICFG_BW-1:0] outstanding [$];

	`include "lbuf_tb_model.svh"

	lbuf_manager_top #(
		.LBW   (LBW),
		.DEPTH (DEPTH)
	) i_dut (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_cfg_we       (i_cfg_we),
		.i_cfg_id       (i_cfg_id),
		.i_cfg_size     (i_cfg_size),
		.i_alloc_rdy    (i_alloc_rdy),
		.i_alloc_id     (i_alloc_id),
		.o_alloc_ack    (o_alloc_ack),
		.i_free_dval    (i_free_dval),
		.i_free_id      (i_free_id),
		.i_re_dval      (i_re_dval),
		.i_blkdone_dval (i_blkdone_dval),
		.o_linear_rdy   (o_linear_rdy),
		.i_linear_ack   (i_linear_ack),
		.o_linear       (o_linear),
		.o_cmd_rdy      (o_cmd_rdy),
		.i_cmd_ack      (i_cmd_ack),
		.o_cmd          (o_cmd)
	);

	initial begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	//==========================================================================
	// Helpers
	//==========================================================================
	function automatic int unsigned rand_range(input int unsigned n);
		int unsigned r;
		r = $random(seed);
		return r % n;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		assert (act_val === exp_val) else begin
			mismatch_count++;
			$display("mismatch %s at cycle %0d: expected %0h, actual %0h",
				name, cycle_count, exp_val, act_val);
		end
	endtask

	task automatic check_outputs();
		check_value("alloc_ack", exp_ack, o_alloc_ack);
		check_value("cmd_rdy", exp_cmd_rdy, o_cmd_rdy);
		check_value("linear_rdy", exp_lin_rdy, o_linear_rdy);
		// Payloads only mean something while offered
		if (exp_cmd_rdy) begin
			check_value("cmd_ring_addr", exp_cmd.addr, o_cmd.addr);
			check_value("cmd_size", exp_cmd.size, o_cmd.size);
			check_value("cmd_id", exp_cmd.id, o_cmd.id);
		end
		if (exp_lin_rdy) begin
			check_value("linear_addr", exp_lin.addr, o_linear.addr);
			check_value("linear_size", exp_lin.size, o_linear.size);
		end
	endtask

	// Phase map over the random run, back-pressure windows inside traffic
	function automatic void set_phase(input int c);
		alloc_en   = (c >= 40 && c < 320) || c >= 360;
		cfg_en     = c < 40 || (c >= 320 && c < 360);
		free_en    = c >= 40;
		free_odds  = (c >= 320 && c < 360) ? 2 : 4;
		cmd_ack_en = !(c >= 140 && c < 190);
		lin_ack_en = !(c >= 230 && c < 280);
	endfunction

	task automatic drive_inputs();
		int unsigned idx;
		predict_outputs(1'b0, '0);
		// Request stays stable until it is acknowledged
		if (granted) begin
			i_alloc_rdy = 1'b0;
		end
		if (!i_alloc_rdy && alloc_en && rand_range(3) == 0) begin
			i_alloc_rdy = 1'b1;
			i_alloc_id  = ICFG_BW'(rand_range(N_ICFG));
		end
		// Table only changes while no block is held
		i_cfg_we   = cfg_en && !i_alloc_rdy && outstanding.size() == 0 &&
			rand_range(2) == 0;
		i_cfg_id   = ICFG_BW'(rand_range(N_ICFG));
		i_cfg_size = (LBW + 1)'(rand_range(MAX_SIZE + 1));
		i_free_dval = 1'b0;
		if (free_en && outstanding.size() != 0 && rand_range(free_odds) == 0) begin
			idx         = rand_range(outstanding.size());
			i_free_dval = 1'b1;
			i_free_id   = outstanding[idx];
			outstanding.delete(idx);
		end
		// DMA writes only what was commanded
		i_re_dval      = wcount < queued_words() && rand_range(2) == 0;
		i_blkdone_dval = alloc_en && rand_range(32) == 0;
		i_cmd_ack      = cmd_ack_en && exp_cmd_rdy && rand_range(4) != 0;
		i_linear_ack   = lin_ack_en && exp_lin_rdy && rand_range(4) != 0;
	endtask

	task automatic run_cycle();
		@(negedge i_clk);
		drive_inputs();
		#1;
		predict_outputs(i_alloc_rdy, i_alloc_id);
		check_outputs();
		// Handshakes as the DUT completes them at the coming edge
		if (i_cmd_ack && o_cmd_rdy) begin
			cmd_taken++;
		end
		if (i_linear_ack && o_linear_rdy) begin
			lin_taken++;
		end
		if (o_alloc_ack) begin
			bp_grants++;
		end
		advance_model();
		granted = exp_ack;
		if (exp_ack) begin
			outstanding.push_back(i_alloc_id);
		end
	endtask

	task automatic check_backpressure();
		assert (bp_grants <= DEPTH) else begin
			other_count++;
			$display("%0d grants while an output ack was held low, limit is %0d",
				bp_grants, DEPTH);
		end
	endtask

	//==========================================================================
	// Timeout
	//==========================================================================
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge i_clk);
			cycle_count++;
		end
		$display("timeout: queues did not drain within %0d cycles", TIMEOUT_CYCLES);
		$display("errors: %0d mismatches, %0d other failures, 1 timeout",
			mismatch_count, other_count);
		$display("sim failed");
		$finish;
	end

	//==========================================================================
	// Main sequence
	//==========================================================================
	initial begin
		seed           = 32'h6fd4;
		mismatch_count = 0;
		other_count    = 0;
		granted        = 1'b0;
		bp_grants      = 0;
		cmd_taken      = 0;
		lin_taken      = 0;
		i_rst          = 1'b1;
		i_cfg_we       = 1'b0;
		i_cfg_id       = '0;
		i_cfg_size     = '0;
		i_alloc_rdy    = 1'b0;
		i_alloc_id     = '0;
		i_free_dval    = 1'b0;
		i_free_id      = '0;
		i_re_dval      = 1'b0;
		i_blkdone_dval = 1'b0;
		i_linear_ack   = 1'b0;
		i_cmd_ack      = 1'b0;
		reset_model();
		repeat (10) @(posedge i_clk);
		@(negedge i_clk);
		i_rst = 1'b0;

		for (int c = 0; c < N_OPS; c++) begin
			set_phase(c);
			// Grants are counted from the start of each held-ack window
			if (c == 140 || c == 230) begin
				bp_grants = 0;
			end
			if (c == 190 || c == 280) begin
				check_backpressure();
			end
			run_cycle();
		end

		// Drain with both acks free, no new requests
		alloc_en   = 1'b0;
		cfg_en     = 1'b0;
		cmd_ack_en = 1'b1;
		lin_ack_en = 1'b1;
		free_odds  = 2;
		while (i_alloc_rdy || cmd_q.size() != 0 || fill_q.size() != 0) begin
			run_cycle();
		end

		assert (grant_count > 0) else begin
			other_count++;
			$display("no allocation was granted during the run");
		end
		assert (cmd_taken == grant_count) else begin
			other_count++;
			$display("DMA commands lost: %0d granted, %0d taken",
				grant_count, cmd_taken);
		end
		assert (lin_taken == grant_count) else begin
			other_count++;
			$display("linear outputs lost: %0d granted, %0d released",
				grant_count, lin_taken);
		end

		$display("errors: %0d mismatches, %0d other failures, %0d grants",
			mismatch_count, other_count, grant_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== lbuf_manager.f ====
+incdir+verification
src/lbuf_cfg_pkg.sv
src/lbuf_types_pkg.sv
src/size_table_decode.sv
src/lbuf_fifo.sv
src/space_allocator.sv
src/fill_tracker.sv
src/lbuf_manager_top.sv
verification/lbuf_manager_tb.sv

// ==== Bender.yml ====
package:
  name: lbuf_manager

sources:
  # Packages first, the RTL depends on both
  - src/lbuf_cfg_pkg.sv
  - src/lbuf_types_pkg.sv
  # RTL, leaf modules before the top level
  - src/size_table_decode.sv
  - src/lbuf_fifo.sv
  - src/space_allocator.sv
  - src/fill_tracker.sv
  - src/lbuf_manager_top.sv
  # Testbench, pulls in its model header from verification/
  - target: test
    include_dirs:
      - verification
    files:
      - verification/lbuf_manager_tb.sv
